/* hdl/video_pkg.sv */
`default_nettype none

package video_pkg;

    // the frame is kept tiny so a full load, trace and stream cycle simulates quickly
    localparam int frame_width = 32;
    localparam int frame_height = 24;
    localparam int frame_pixels = frame_width * frame_height;

    localparam int pixel_bits = 24;                  // one rgb word, 8 bits per channel
    localparam int addr_bits = $clog2(frame_pixels);  // 768 words need 10 bits

    // pure green, red and blue channels cleared
    localparam logic [pixel_bits-1:0] line_colour = 24'h00ff00;

endpackage

`default_nettype wire

/* hdl/line_geometry_pkg.sv */
`default_nettype none

package line_geometry_pkg;

    // the half turn from 0 to 180 degrees is split into 32 equal steps
    localparam int angle_steps = 32;
    localparam int angle_bits = $clog2(angle_steps);

    // sine and cosine are signed q2.13 values, so 1.0 is 8192
    localparam int trig_bits = 16;
    localparam int frac_bits = 13;

    localparam int radius_bits = 8;         // radius is unsigned

    // the line is walked for line_length unit steps from its origin
    localparam int line_length = 64;
    localparam int step_bits = 7;           // wide enough to hold line_length itself

    // signed width of products and coordinates, so no sum can overflow
    localparam int coord_bits = 24;

    // Quarter-wave table rule shared by the ROM and the reference model.
    // Entry k is round(sin(k * pi / 32) * 8192) for k from 0 to 16, so entry 16
    // is exactly 8192 and the quarter wave covers 0 to 90 degrees in 16 steps.
    // The other half of the range is reached by symmetry:
    //   sin(s) = table[s]      for s up to 16, table[32 - s] above
    //   cos(s) = table[16 - s] for s up to 16, -table[s - 16] above
    // Every product is floored by an arithmetic right shift of frac_bits.

endpackage

`default_nettype wire

/* hdl/trig_rom.sv */
`default_nettype none

module trig_rom (
    input  wire [line_geometry_pkg::angle_bits-1:0]         angle,
    output logic signed [line_geometry_pkg::trig_bits-1:0]  sine,
    output logic signed [line_geometry_pkg::trig_bits-1:0]  cosine
);
    import line_geometry_pkg::*;

    logic [angle_bits-1:0] sine_index;
    logic [angle_bits-1:0] cosine_index;
    logic                  upper_half;    // angle lies above 90 degrees

    function automatic logic signed [trig_bits-1:0] quarter_sine(
        input logic [angle_bits-1:0] k
    );
        case (k)
            5'd0:    return trig_bits'(0);
            5'd1:    return trig_bits'(803);
            5'd2:    return trig_bits'(1598);
            5'd3:    return trig_bits'(2378);
            5'd4:    return trig_bits'(3135);
            5'd5:    return trig_bits'(3862);
            5'd6:    return trig_bits'(4551);
            5'd7:    return trig_bits'(5197);
            5'd8:    return trig_bits'(5793);
            5'd9:    return trig_bits'(6333);
            5'd10:   return trig_bits'(6811);
            5'd11:   return trig_bits'(7225);
            5'd12:   return trig_bits'(7568);
            5'd13:   return trig_bits'(7839);
            5'd14:   return trig_bits'(8035);
            5'd15:   return trig_bits'(8153);
            default: return trig_bits'(8192);  // only 16 is reached, the index never exceeds it
        endcase
    endfunction

    assign upper_half = angle > angle_bits'(angle_steps / 2);

    always_comb begin
        if (upper_half) begin
            sine_index = angle_bits'(angle_steps - int'(angle));          // sin(180 - a) = sin(a)
            cosine_index = angle_bits'(int'(angle) - angle_steps / 2);    // cos(a) = -sin(a - 90)
        end else begin
            sine_index = angle;
            cosine_index = angle_bits'(angle_steps / 2 - int'(angle));    // cos(a) = sin(90 - a)
        end
    end

    assign sine = quarter_sine(sine_index);
    assign cosine = upper_half ? -quarter_sine(cosine_index) : quarter_sine(cosine_index);

endmodule

`default_nettype wire

/* hdl/frame_loader.sv */
`default_nettype none

module frame_loader (
    input  wire                                 clock,
    input  wire                                 reset,
    input  wire                                 enable,
    input  wire                                 in_empty,
    input  wire  [video_pkg::pixel_bits-1:0]    in_dout,
    output logic                                rd_en,
    output logic                                load_we,
    output logic [video_pkg::addr_bits-1:0]     load_addr,
    output logic [video_pkg::pixel_bits-1:0]    load_pixel,
    output logic                                frame_loaded
);
    import video_pkg::*;

    logic last_word;

    // the input FIFO shows its head word while not empty, so a read and a write share a cycle
    assign rd_en = enable && !in_empty && !frame_loaded;  // hold off while the done pulse is out
    assign load_we = rd_en;
    assign load_pixel = in_dout;
    assign last_word = load_addr == addr_bits'(frame_pixels - 1);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            load_addr <= '0;
            frame_loaded <= 1'b0;
        end else begin
            frame_loaded <= load_we && last_word;
            if (load_we) begin
                if (last_word) begin
                    load_addr <= '0;  // wrap so the next frame starts at the top left
                end else begin
                    load_addr <= load_addr + 1'b1;
                end
            end
        end
    end

    // the last word is followed by the done pulse and not by a write into the next frame
    last_word_then_loaded: assert property (
        @(posedge clock) disable iff (reset)
        (load_we && last_word) |=> (frame_loaded && !load_we)
    );

endmodule

`default_nettype wire

/* hdl/line_tracer.sv */
`default_nettype none

module line_tracer (
    input  wire                                         clock,
    input  wire                                         reset,
    input  wire                                         trace_start,
    input  wire  [line_geometry_pkg::angle_bits-1:0]    angle,
    input  wire  [line_geometry_pkg::radius_bits-1:0]   radius,
    output logic                                        paint_we,
    output logic [video_pkg::addr_bits-1:0]             paint_addr,
    output logic                                        trace_done
);
    import video_pkg::*;
    import line_geometry_pkg::*;

    logic [angle_bits-1:0]          angle_q;
    logic [radius_bits-1:0]         radius_q;
    logic signed [trig_bits-1:0]    sine;
    logic signed [trig_bits-1:0]    cosine;
    logic signed [trig_bits-1:0]    neg_sine;
    logic                           running;
    logic [step_bits-1:0]           step;
    logic signed [step_bits:0]      step_s;
    logic                           last_step;
    logic signed [coord_bits-1:0]   x0;
    logic signed [coord_bits-1:0]   y0;
    logic signed [coord_bits-1:0]   dx1;
    logic signed [coord_bits-1:0]   dy1;
    logic                           v1;
    logic                           l1;
    logic signed [coord_bits-1:0]   x2;
    logic signed [coord_bits-1:0]   y2;
    logic                           v2;
    logic                           l2;
    logic                           in_frame;

    trig_rom u_trig_rom (
        .angle(angle_q),
        .sine(sine),
        .cosine(cosine)
    );

    assign neg_sine = -sine;              // the line runs along (-sin, cos)
    assign step_s = $signed({1'b0, step});
    assign last_step = step == step_bits'(line_length - 1);
    assign in_frame = x2 >= 0 && x2 < frame_width && y2 >= 0 && y2 < frame_height;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            running <= 1'b0;
            step <= '0;
            v1 <= 1'b0;
            l1 <= 1'b0;
            v2 <= 1'b0;
            l2 <= 1'b0;
            paint_we <= 1'b0;
            trace_done <= 1'b0;
        end else begin
            if (trace_start) begin
                running <= 1'b1;
                step <= '0;
            end else if (running) begin
                step <= step + 1'b1;
                running <= !last_step;
            end
            v1 <= running;
            l1 <= running && last_step;
            v2 <= v1;
            l2 <= l1;
            paint_we <= v2 && in_frame;   // clipped steps still flow, only their write is dropped
            trace_done <= l2;
        end
    end

    always_ff @(posedge clock) begin
        if (trace_start) begin
            angle_q <= angle;
            radius_q <= radius;
        end
        if (running && step == '0) begin  // origin is ready one cycle before step 0 needs it
            x0 <= ($signed({1'b0, radius_q}) * cosine) >>> frac_bits;
            y0 <= ($signed({1'b0, radius_q}) * sine) >>> frac_bits;
        end
        dx1 <= (step_s * neg_sine) >>> frac_bits;
        dy1 <= (step_s * cosine) >>> frac_bits;
        x2 <= x0 + dx1;
        y2 <= y0 + dy1;
        paint_addr <= addr_bits'(y2 * frame_width + x2);
    end

    paint_inside_frame: assert property (
        @(posedge clock) disable iff (reset)
        paint_we |-> paint_addr < frame_pixels
    );

endmodule

`default_nettype wire

/* hdl/frame_buffer.sv */
`default_nettype none

module frame_buffer (
    input  wire                                 clock,
    input  wire                                 tracing,
    input  wire                                 load_we,
    input  wire  [video_pkg::addr_bits-1:0]     load_addr,
    input  wire  [video_pkg::pixel_bits-1:0]    load_pixel,
    input  wire                                 paint_we,
    input  wire  [video_pkg::addr_bits-1:0]     paint_addr,
    input  wire  [video_pkg::addr_bits-1:0]     read_addr,
    output logic [video_pkg::pixel_bits-1:0]    read_pixel
);
    import video_pkg::*;

    logic [pixel_bits-1:0]  mem [frame_pixels];
    logic                   we;
    logic [addr_bits-1:0]   waddr;
    logic [pixel_bits-1:0]  wdata;

    // one write port shared by the loader and the tracer, the phase picks the owner
    always_comb begin
        if (tracing) begin
            we = paint_we;
            waddr = paint_addr;
            wdata = line_colour;
        end else begin
            we = load_we;
            waddr = load_addr;
            wdata = load_pixel;
        end
    end

    always_ff @(posedge clock) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    assign read_pixel = mem[read_addr];  // asynchronous read feeds the output FIFO directly

endmodule

`default_nettype wire

/* hdl/frame_streamer.sv */
`default_nettype none

module frame_streamer (
    input  wire                                 clock,
    input  wire                                 reset,
    input  wire                                 enable,
    input  wire                                 out_full,
    output logic [video_pkg::addr_bits-1:0]     read_addr,
    input  wire  [video_pkg::pixel_bits-1:0]    read_pixel,
    output logic                                out_wr_en,
    output logic [video_pkg::pixel_bits-1:0]    out_din,
    output logic                                stream_done
);
    import video_pkg::*;

    logic [addr_bits-1:0] index;
    logic                 last_pixel;

    assign out_wr_en = enable && !out_full;
    assign read_addr = index;
    assign out_din = read_pixel;
    assign last_pixel = index == addr_bits'(frame_pixels - 1);
    assign stream_done = out_wr_en && last_pixel;  // the top leaves the streaming phase on this edge

    // the index only moves on an accepted write, so back-pressure simply holds it
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            index <= '0;
        end else if (out_wr_en) begin
            if (last_pixel) begin
                index <= '0;
            end else begin
                index <= index + 1'b1;
            end
        end
    end

    // a full FIFO blocks the write and the same pixel is offered again next cycle
    full_blocks_write: assert property (
        @(posedge clock) disable iff (reset)
        out_full |-> (!out_wr_en ##1 $stable(read_addr))
    );

endmodule

`default_nettype wire

/* hdl/hough_overlay_top.sv */
`default_nettype none

module hough_overlay_top (
    input  wire                                         clock,
    input  wire                                         reset,
    input  wire                                         in_empty,
    input  wire  [video_pkg::pixel_bits-1:0]            in_dout,
    output logic                                        rd_en,
    input  wire  [line_geometry_pkg::angle_bits-1:0]    angle,
    input  wire  [line_geometry_pkg::radius_bits-1:0]   radius,
    input  wire                                         out_full,
    output logic                                        out_wr_en,
    output logic [video_pkg::pixel_bits-1:0]            out_din
);
    import video_pkg::*;
    import line_geometry_pkg::*;

    logic                   loading;       // the phase register, one hot
    logic                   tracing;
    logic                   streaming;
    logic [angle_bits-1:0]  angle_q;
    logic [radius_bits-1:0] radius_q;
    logic                   trace_start;
    logic                   frame_loaded;
    logic                   trace_done;
    logic                   stream_done;
    logic                   load_we;
    logic [addr_bits-1:0]   load_addr;
    logic [pixel_bits-1:0]  load_pixel;
    logic                   paint_we;
    logic [addr_bits-1:0]   paint_addr;
    logic [addr_bits-1:0]   read_addr;
    logic [pixel_bits-1:0]  read_pixel;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            loading <= 1'b1;
            tracing <= 1'b0;
            streaming <= 1'b0;
            trace_start <= 1'b0;
        end else begin
            trace_start <= frame_loaded;  // gives the tracer the parameters sampled below
            if (frame_loaded) begin
                loading <= 1'b0;
                tracing <= 1'b1;
            end
            if (trace_done) begin
                tracing <= 1'b0;
                streaming <= 1'b1;
            end
            if (stream_done) begin
                streaming <= 1'b0;
                loading <= 1'b1;
            end
        end
    end

    // each frame uses the line parameters present when its last pixel arrived
    always_ff @(posedge clock) begin
        if (frame_loaded) begin
            angle_q <= angle;
            radius_q <= radius;
        end
    end

    frame_loader u_frame_loader (
        .clock(clock),
        .reset(reset),
        .enable(loading),
        .in_empty(in_empty),
        .in_dout(in_dout),
        .rd_en(rd_en),
        .load_we(load_we),
        .load_addr(load_addr),
        .load_pixel(load_pixel),
        .frame_loaded(frame_loaded)
    );

    line_tracer u_line_tracer (
        .clock(clock),
        .reset(reset),
        .trace_start(trace_start),
        .angle(angle_q),
        .radius(radius_q),
        .paint_we(paint_we),
        .paint_addr(paint_addr),
        .trace_done(trace_done)
    );

    frame_buffer u_frame_buffer (
        .clock(clock),
        .tracing(tracing),
        .load_we(load_we),
        .load_addr(load_addr),
        .load_pixel(load_pixel),
        .paint_we(paint_we),
        .paint_addr(paint_addr),
        .read_addr(read_addr),
        .read_pixel(read_pixel)
    );

    frame_streamer u_frame_streamer (
        .clock(clock),
        .reset(reset),
        .enable(streaming),
        .out_full(out_full),
        .read_addr(read_addr),
        .read_pixel(read_pixel),
        .out_wr_en(out_wr_en),
        .out_din(out_din),
        .stream_done(stream_done)
    );

    // paint writes land only while the buffer is owned by the tracer
    paint_only_when_tracing: assert property (
        @(posedge clock) disable iff (reset)
        paint_we |-> tracing && $onehot({loading, tracing, streaming})
    );

endmodule

`default_nettype wire

/* bench/overlay_checker.sv */
`default_nettype none

module overlay_checker (
    input  wire                                         clock,
    input  wire                                         reset,
    input  wire                                         in_empty,
    input  wire  [video_pkg::pixel_bits-1:0]            in_dout,
    input  wire                                         rd_en,
    input  wire  [line_geometry_pkg::angle_bits-1:0]    angle,
    input  wire  [line_geometry_pkg::radius_bits-1:0]   radius,
    input  wire                                         out_full,
    input  wire                                         out_wr_en,
    input  wire  [video_pkg::pixel_bits-1:0]            out_din,
    output int                                          value_errors,
    output int                                          protocol_errors,
    output int                                          frame_count,
    output int                                          pixel_count
);
    timeunit 1ns;
    timeprecision 100ps;
    import video_pkg::*;
    import line_geometry_pkg::*;

    localparam real pi_value = 3.141592653589793;

    logic [pixel_bits-1:0]  input_frame [frame_pixels];
    logic [pixel_bits-1:0]  expected_frame [frame_pixels];
    int                     quarter_table [angle_steps / 2 + 1];
    int                     in_index;
    int                     out_index;
    int                     frames_ready;   // loaded frames whose output has not finished

    initial begin
        for (int k = 0; k <= angle_steps / 2; k++) begin
            quarter_table[k] = $rtoi((1 << frac_bits) * $sin(k * pi_value / angle_steps) + 0.5);
        end
    end

    function automatic int sine_of(input int s);
        if (s <= angle_steps / 2) begin
            return quarter_table[s];
        end else begin
            return quarter_table[angle_steps - s];  // sin(180 - a) = sin(a)
        end
    endfunction

    function automatic int cosine_of(input int s);
        if (s <= angle_steps / 2) begin
            return quarter_table[angle_steps / 2 - s];
        end else begin
            return -quarter_table[s - angle_steps / 2];
        end
    endfunction

    // the loaded frame with every in-frame step of the line painted green
    task automatic build_expected(input int a, input int r);
        int x0;
        int y0;
        int x;
        int y;
        for (int i = 0; i < frame_pixels; i++) begin
            expected_frame[i] = input_frame[i];
        end
        x0 = (r * cosine_of(a)) >>> frac_bits;
        y0 = (r * sine_of(a)) >>> frac_bits;
        for (int t = 0; t < line_length; t++) begin
            x = x0 + ((t * -sine_of(a)) >>> frac_bits);
            y = y0 + ((t * cosine_of(a)) >>> frac_bits);
            if (x >= 0 && x < frame_width && y >= 0 && y < frame_height) begin
                expected_frame[y * frame_width + x] = line_colour;
            end
        end
    endtask

    always @(posedge clock or posedge reset) begin
        if (reset) begin
            in_index = 0;
            out_index = 0;
            frames_ready = 0;
            value_errors = 0;
            protocol_errors = 0;
            frame_count = 0;
            pixel_count = 0;
        end else begin
            if (rd_en && in_empty) begin
                $display("rd_en was high at %0d ns while the input FIFO was empty", $time);
                protocol_errors++;
            end else if (rd_en) begin
                input_frame[in_index] = in_dout;
                if (in_index == frame_pixels - 1) begin
                    build_expected(angle, radius);  // line parameters as they stand at the load
                    in_index = 0;
                    frames_ready++;
                end else begin
                    in_index++;
                end
            end
            if (out_wr_en && out_full) begin
                $display("out_wr_en was high at %0d ns while the output FIFO was full", $time);
                protocol_errors++;
            end
            if (out_wr_en && frames_ready == 0) begin
                $display("a pixel was written at %0d ns with no loaded frame waiting", $time);
                protocol_errors++;
            end else if (out_wr_en) begin
                if (out_din !== expected_frame[out_index]) begin
                    $display("ERROR at %0d ns: out_din expected %h, actual %h (frame %0d, pixel %0d)",
                             $time, expected_frame[out_index], out_din, frame_count, out_index);
                    value_errors++;
                end
                pixel_count++;
                if (out_index == frame_pixels - 1) begin
                    out_index = 0;
                    frames_ready--;
                    frame_count++;
                end else begin
                    out_index++;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* bench/hough_overlay_tb.sv */
`default_nettype none

module hough_overlay_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import video_pkg::*;
    import line_geometry_pkg::*;

    localparam int row_count = 10;
    localparam int frame_timeout = 20000;  // cycles for one frame to go in and come out

    logic                   clock;
    logic                   reset;
    logic                   in_empty;
    logic [pixel_bits-1:0]  in_dout;
    logic                   rd_en;
    logic [angle_bits-1:0]  angle;
    logic [radius_bits-1:0] radius;
    logic                   out_full;
    logic                   out_wr_en;
    logic [pixel_bits-1:0]  out_din;
    int                     value_errors;
    int                     protocol_errors;
    int                     frames_seen;
    int                     pixels_seen;
    int                     run_errors;
    integer                 seed;
    int                     row_angle [row_count];
    int                     row_radius [row_count];
    int                     row_random [row_count];     // 0 sends a ramp, 1 random pixels
    int                     row_in_stall [row_count];   // percent of cycles the input FIFO is empty
    int                     row_out_stall [row_count];  // percent of cycles the output FIFO is full
    logic [pixel_bits-1:0]  frame_words [frame_pixels];

    hough_overlay_top UUT (
        .clock(clock),
        .reset(reset),
        .in_empty(in_empty),
        .in_dout(in_dout),
        .rd_en(rd_en),
        .angle(angle),
        .radius(radius),
        .out_full(out_full),
        .out_wr_en(out_wr_en),
        .out_din(out_din)
    );

    overlay_checker u_checker (
        .clock(clock),
        .reset(reset),
        .in_empty(in_empty),
        .in_dout(in_dout),
        .rd_en(rd_en),
        .angle(angle),
        .radius(radius),
        .out_full(out_full),
        .out_wr_en(out_wr_en),
        .out_din(out_din),
        .value_errors(value_errors),
        .protocol_errors(protocol_errors),
        .frame_count(frames_seen),
        .pixel_count(pixels_seen)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic add_row(input int r, input int a, input int rad, input int rnd,
                           input int in_stall, input int out_stall);
        row_angle[r] = a;
        row_radius[r] = rad;
        row_random[r] = rnd;
        row_in_stall[r] = in_stall;
        row_out_stall[r] = out_stall;
    endtask

    function automatic logic stall_now(input int percent);
        return ($unsigned($random(seed)) % 100) < percent;
    endfunction

    // one row is one frame, fed through the input FIFO model until its output is complete
    task automatic run_frame(input int r);
        int idx;
        int cycles;
        int loaded_edges;
        idx = 0;
        cycles = 0;
        loaded_edges = 0;
        for (int i = 0; i < frame_pixels; i++) begin
            frame_words[i] = row_random[r] ? pixel_bits'($random(seed))
                                           : pixel_bits'(r * 65536 + i);
        end
        angle = angle_bits'(row_angle[r]);
        radius = radius_bits'(row_radius[r]);
        while (frames_seen <= r && cycles < frame_timeout) begin
            if (loaded_edges >= 2) begin
                // the top has taken its sample, so the next line is presented early
                angle = angle_bits'(row_angle[(r + 1) % row_count]);
                radius = radius_bits'(row_radius[(r + 1) % row_count]);
            end
            in_empty = idx == frame_pixels || stall_now(row_in_stall[r]);
            in_dout = frame_words[idx % frame_pixels];
            out_full = stall_now(row_out_stall[r]);
            @(posedge clock);
            if (rd_en) begin
                idx++;  // the head word was taken, show the next one
            end
            if (idx == frame_pixels) begin
                loaded_edges++;
            end
            #1;
            cycles++;
        end
        if (frames_seen <= r) begin
            $display("frame %0d did not come out within %0d cycles", r, frame_timeout);
            run_errors++;
        end
    endtask

    initial begin
        seed = 19917;
        reset = 1'b1;
        in_empty = 1'b1;
        in_dout = '0;
        angle = '0;
        radius = '0;
        out_full = 1'b0;
        run_errors = 0;
        //      row angle radius random in% out%
        add_row(0,  0,   10,   0,     0,  0);   // vertical line at x = 10
        add_row(1,  16,  5,    0,     0,  0);   // horizontal line, only (0,5) inside
        add_row(2,  4,   15,   1,     0,  0);
        add_row(3,  2,   30,   1,     0,  0);   // runs off the bottom edge
        add_row(4,  24,  20,   1,     0,  0);
        add_row(5,  10,  25,   1,     30, 0);
        add_row(6,  8,   255,  0,     0,  30);  // whole line outside the frame
        add_row(7,  12,  18,   1,     40, 40);
        add_row(8,  28,  0,    1,     20, 50);
        add_row(9,  6,   8,    0,     50, 20);
        repeat (16) @(posedge clock);
        #1;
        reset = 1'b0;
        for (int r = 0; r < row_count && run_errors == 0; r++) begin
            run_frame(r);
        end
        in_empty = 1'b1;
        repeat (100) @(posedge clock);  // idle time so a stray write would still be seen
        if (frames_seen != row_count || pixels_seen != row_count * frame_pixels) begin
            $display("the output held %0d frames and %0d pixels instead of %0d frames of %0d",
                     frames_seen, pixels_seen, row_count, frame_pixels);
            run_errors++;
        end
        $display("frames %0d, pixels %0d, value errors %0d, protocol errors %0d, run errors %0d",
                 frames_seen, pixels_seen, value_errors, protocol_errors, run_errors);
        if (value_errors == 0 && protocol_errors == 0 && run_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
hdl/video_pkg.sv
hdl/line_geometry_pkg.sv
hdl/trig_rom.sv
hdl/frame_loader.sv
hdl/line_tracer.sv
hdl/frame_buffer.sv
hdl/frame_streamer.sv
hdl/hough_overlay_top.sv
bench/overlay_checker.sv
bench/hough_overlay_tb.sv

/* Bender.yml */
package:
  name: hough_overlay

sources:
  - hdl/video_pkg.sv
  - hdl/line_geometry_pkg.sv
  - hdl/trig_rom.sv
  - hdl/frame_loader.sv
  - hdl/line_tracer.sv
  - hdl/frame_buffer.sv
  - hdl/frame_streamer.sv
  - hdl/hough_overlay_top.sv
  - target: test
    files:
      - bench/overlay_checker.sv
      - bench/hough_overlay_tb.sv
